/* design/rf_pkg.sv */
// default widths for a 32 x 32-bit integer file with x0 tied to zero; override through top parameters

package rf_pkg;

  // operand and register width.
  localparam int data_width_c = 32;

  // architectural register count.
  localparam int num_regs_c = 32;

  // address width follows the register count.
  localparam int reg_addr_width_c = $clog2(num_regs_c);

  // nonzero makes x0 constant zero and never written.
  localparam int x0_zero_c = 1;

endpackage : rf_pkg

/* design/alu_pkg.sv */
// RV32I opcode and funct encodings for the supported OP/OP-IMM subset only; shifts and sltu are not covered

package alu_pkg;

  // operations the ALU stage can perform.
  typedef enum logic [2:0] {
    op_add     = 3'd0,
    op_sub     = 3'd1,
    op_and     = 3'd2,
    op_or      = 3'd3,
    op_xor     = 3'd4,
    op_slt     = 3'd5,
    op_illegal = 3'd6
  } alu_op_e;

  // major opcodes.
  localparam logic [6:0] opc_op_c     = 7'b0110011; // register-register.
  localparam logic [6:0] opc_op_imm_c = 7'b0010011; // register-immediate.

  // funct3 values.
  localparam logic [2:0] f3_add_c = 3'b000; // add, sub, addi.
  localparam logic [2:0] f3_slt_c = 3'b010;
  localparam logic [2:0] f3_xor_c = 3'b100;
  localparam logic [2:0] f3_or_c  = 3'b110;
  localparam logic [2:0] f3_and_c = 3'b111;

  // funct7 values; the alternate form sets bit 30 of the word and selects sub.
  localparam logic [6:0] f7_base_c = 7'b0000000;
  localparam logic [6:0] f7_alt_c  = 7'b0100000;

endpackage : alu_pkg

/* design/rf_read_if.sv */
// two read ports sharing one enable; addresses are sampled by the register file, data is combinational
`timescale 1ns/1ps

interface rf_read_if #(
  parameter int addr_width_p = 5,
  parameter int data_width_p = 32
) ();

  logic                    en;        // high on instruction acceptance.
  logic [addr_width_p-1:0] rs1_addr;
  logic [addr_width_p-1:0] rs2_addr;
  logic [data_width_p-1:0] rs1_data;
  logic [data_width_p-1:0] rs2_data;

  // decoder side.
  modport requester (output en, output rs1_addr, output rs2_addr);

  // register file side.
  modport provider (
    input  en,
    input  rs1_addr,
    input  rs2_addr,
    output rs1_data,
    output rs2_data
  );

  // ALU stage side.
  modport consumer (input rs1_data, input rs2_data);

endinterface : rf_read_if

/* design/dec_alu_if.sv */
// decoded operation from stage one to the ALU stage; a transfer needs valid and ready on one edge
`timescale 1ns/1ps

interface dec_alu_if import alu_pkg::*; #(
  parameter int addr_width_p = 5,
  parameter int data_width_p = 32
) ();

  logic                    valid;
  logic                    ready;
  alu_op_e                 op;
  logic [addr_width_p-1:0] rd;
  logic [data_width_p-1:0] imm;     // sign-extended I-immediate.
  logic                    use_imm; // second operand from imm.

  modport source (output valid, output op, output rd, output imm, output use_imm, input ready);

  modport sink (input valid, input op, input rd, input imm, input use_imm, output ready);

endinterface : dec_alu_if

/* design/int_regfile.sv */
// one write port, two reads from registered addresses; array is plain enabled flops, addresses must be < num_regs_p
`timescale 1ns/1ps

module int_regfile #(
  parameter int data_width_p = 32,
  parameter int num_regs_p   = 32,
  parameter int addr_width_p = 5,
  parameter int x0_zero_p    = 1
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  rf_read_if.provider             rd_prov,
  input  logic                    we_i,
  input  logic [addr_width_p-1:0] waddr_i,
  input  logic [data_width_p-1:0] wdata_i
);

  // first entry that has real storage.
  localparam int start_idx_lp = (x0_zero_p != 0) ? 1 : 0;

  logic [num_regs_p-1:start_idx_lp]                   we_onehot;
  logic [num_regs_p-1:start_idx_lp][data_width_p-1:0] mem_q;
  logic [num_regs_p-1:0][data_width_p-1:0]            mem_rd;
  logic [addr_width_p-1:0]                            rs1_addr_q;
  logic [addr_width_p-1:0]                            rs2_addr_q;

  // write address decode, one enable per entry.
  always_comb begin
    we_onehot = '0;
    for (int i = start_idx_lp; i < num_regs_p; i++) begin
      we_onehot[i] = we_i && (waddr_i == addr_width_p'(i));
    end
  end

  // storage array.
  always_ff @(posedge clk_i) begin
    for (int i = start_idx_lp; i < num_regs_p; i++) begin
      if (we_onehot[i]) begin
        mem_q[i] <= wdata_i;
      end
    end
  end

  // read view with x0 folded in.
  if (x0_zero_p != 0) begin : g_x0_zero
    assign mem_rd = {mem_q, {data_width_p{1'b0}}};
  end else begin : g_x0_reg
    assign mem_rd = mem_q;
  end

  // read addresses hold while stage one stalls.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rs1_addr_q <= '0;
      rs2_addr_q <= '0;
    end else if (rd_prov.en) begin
      rs1_addr_q <= rd_prov.rs1_addr;
      rs2_addr_q <= rd_prov.rs2_addr;
    end
  end

  // array read after the write edge, so a dependent
  // instruction accepted on the write edge sees the new value.
  assign rd_prov.rs1_data = mem_rd[rs1_addr_q];
  assign rd_prov.rs2_data = mem_rd[rs2_addr_q];

  // the ALU stage must never target x0 when it is tied off.
  a_no_x0_write : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    we_i |-> ((x0_zero_p == 0) || (waddr_i != '0))
  ) else $error("write to x0 with x0 tied to zero");

endmodule : int_regfile

/* design/instr_decoder.sv */
// accepts RV32I OP/OP-IMM words; any other encoding decodes to op_illegal, data width must be at least 12
`timescale 1ns/1ps

module instr_decoder import alu_pkg::*; #(
  parameter int data_width_p = 32,
  parameter int addr_width_p = 5
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  output logic        instr_ready_o,
  rf_read_if.requester rd_req,
  dec_alu_if.source   dec
);

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  alu_op_e                 base_op;
  alu_op_e                 op_d;
  logic                    use_imm_d;
  logic                    accept;
  logic                    valid_q;
  alu_op_e                 op_q;
  logic [addr_width_p-1:0] rd_q;
  logic [data_width_p-1:0] imm_q;
  logic                    use_imm_q;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // stage one is free or moves on this edge.
  assign instr_ready_o = !valid_q || dec.ready;
  assign accept        = instr_valid_i && instr_ready_o;

  always_comb begin
    case (funct3)
      f3_add_c: base_op = op_add;
      f3_slt_c: base_op = op_slt;
      f3_xor_c: base_op = op_xor;
      f3_or_c:  base_op = op_or;
      f3_and_c: base_op = op_and;
      default:  base_op = op_illegal; // shifts, sltu.
    endcase
    op_d      = op_illegal;
    use_imm_d = 1'b0;
    if (opcode == opc_op_c) begin
      if (funct7 == f7_base_c) begin
        op_d = base_op;
      end else if ((funct7 == f7_alt_c) && (funct3 == f3_add_c)) begin
        op_d = op_sub;
      end
    end else if (opcode == opc_op_imm_c) begin
      op_d      = base_op;
      use_imm_d = 1'b1;
    end
  end

  // source addresses go to the register file on the accepting edge.
  assign rd_req.en       = accept;
  assign rd_req.rs1_addr = addr_width_p'(instr_i[19:15]);
  assign rd_req.rs2_addr = addr_width_p'(instr_i[24:20]);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (dec.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q      <= op_d;
      rd_q      <= addr_width_p'(instr_i[11:7]);
      imm_q     <= {{(data_width_p-12){instr_i[31]}}, instr_i[31:20]};
      use_imm_q <= use_imm_d;
    end
  end

  assign dec.valid   = valid_q;
  assign dec.op      = op_q;
  assign dec.rd      = rd_q;
  assign dec.imm     = imm_q;
  assign dec.use_imm = use_imm_q;

  a_op_hold : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (dec.valid && !dec.ready) |=> (dec.valid && $stable(dec.op))
  ) else $error("decoded op changed while stalled");

endmodule : instr_decoder

/* design/alu_stage.sv */
// single result register; write-back happens on the transfer edge, illegal ops return zero and skip write-back
`timescale 1ns/1ps

module alu_stage import alu_pkg::*; #(
  parameter int data_width_p = 32,
  parameter int addr_width_p = 5
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  rf_read_if.consumer             rd_cons,
  dec_alu_if.sink                 dec,
  output logic                    we_o,
  output logic [addr_width_p-1:0] waddr_o,
  output logic [data_width_p-1:0] wdata_o,
  output logic                    result_valid_o,
  input  logic                    result_ready_i,
  output logic [addr_width_p-1:0] result_rd_o,
  output logic [data_width_p-1:0] result_data_o,
  output logic                    result_illegal_o
);

  logic [data_width_p-1:0] opnd_a;
  logic [data_width_p-1:0] opnd_b;
  logic [data_width_p-1:0] alu_res;
  logic                    is_illegal;
  logic                    xfer;
  logic                    res_valid_q;
  logic [addr_width_p-1:0] res_rd_q;
  logic [data_width_p-1:0] res_data_q;
  logic                    res_illegal_q;

  // operand select.
  assign opnd_a = rd_cons.rs1_data;
  assign opnd_b = dec.use_imm ? dec.imm : rd_cons.rs2_data;

  always_comb begin
    case (dec.op)
      op_add:  alu_res = opnd_a + opnd_b;
      op_sub:  alu_res = opnd_a - opnd_b;
      op_and:  alu_res = opnd_a & opnd_b;
      op_or:   alu_res = opnd_a | opnd_b;
      op_xor:  alu_res = opnd_a ^ opnd_b;
      op_slt:  alu_res = data_width_p'($signed(opnd_a) < $signed(opnd_b));
      default: alu_res = '0; // illegal gives zero.
    endcase
  end

  assign is_illegal = (dec.op == op_illegal);

  // result register free or draining.
  assign dec.ready = !res_valid_q || result_ready_i;
  assign xfer      = dec.valid && dec.ready;

  // write-back lands on the same edge the result is captured.
  assign we_o    = xfer && !is_illegal && (dec.rd != '0);
  assign waddr_o = dec.rd;
  assign wdata_o = alu_res;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res_valid_q <= 1'b0;
    end else if (xfer) begin
      res_valid_q <= 1'b1;
    end else if (result_ready_i) begin
      res_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      res_rd_q      <= dec.rd;
      res_data_q    <= alu_res;
      res_illegal_q <= is_illegal;
    end
  end

  assign result_valid_o   = res_valid_q;
  assign result_rd_o      = res_rd_q;
  assign result_data_o    = res_data_q;
  assign result_illegal_o = res_illegal_q;

  a_result_hold : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (result_valid_o && !result_ready_i) |=> (result_valid_o && $stable(result_data_o))
  ) else $error("result data changed while back-pressured");

endmodule : alu_stage

/* design/int_exec_top.sv */
// one-cycle execute slice for RV32I OP/OP-IMM; no loads, stores, branches or shifts, one write per cycle
`timescale 1ns/1ps

module int_exec_top import rf_pkg::*; #(
  parameter int data_width_p = data_width_c,
  parameter int num_regs_p   = num_regs_c,
  parameter int addr_width_p = reg_addr_width_c,
  parameter int x0_zero_p    = x0_zero_c
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    instr_valid_i,
  input  logic [31:0]             instr_i,
  output logic                    instr_ready_o,
  output logic                    result_valid_o,
  input  logic                    result_ready_i,
  output logic [addr_width_p-1:0] result_rd_o,
  output logic [data_width_p-1:0] result_data_o,
  output logic                    result_illegal_o
);

  logic                    rf_we;
  logic [addr_width_p-1:0] rf_waddr;
  logic [data_width_p-1:0] rf_wdata;

  rf_read_if #(.addr_width_p(addr_width_p), .data_width_p(data_width_p)) rd_bus ();
  dec_alu_if #(.addr_width_p(addr_width_p), .data_width_p(data_width_p)) dec_bus ();

  instr_decoder #(
    .data_width_p(data_width_p),
    .addr_width_p(addr_width_p)
  ) u_decoder (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .rd_req        (rd_bus.requester),
    .dec           (dec_bus.source)
  );

  int_regfile #(
    .data_width_p(data_width_p),
    .num_regs_p  (num_regs_p),
    .addr_width_p(addr_width_p),
    .x0_zero_p   (x0_zero_p)
  ) u_regfile (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .rd_prov (rd_bus.provider),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata)
  );

  alu_stage #(
    .data_width_p(data_width_p),
    .addr_width_p(addr_width_p)
  ) u_alu (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .rd_cons         (rd_bus.consumer),
    .dec             (dec_bus.sink),
    .we_o            (rf_we),
    .waddr_o         (rf_waddr),
    .wdata_o         (rf_wdata),
    .result_valid_o  (result_valid_o),
    .result_ready_i  (result_ready_i),
    .result_rd_o     (result_rd_o),
    .result_data_o   (result_data_o),
    .result_illegal_o(result_illegal_o)
  );

endmodule : int_exec_top

/* tb/int_exec_tb.sv */
// drives 400 OP/OP-IMM words into int_exec_top; register contents are only read after being written
`timescale 1ns/1ps

module int_exec_tb;

  localparam int num_instr_c  = 400;
  localparam int max_cycles_c = 3000; // 400 instructions at up to ~5 cycles, plus margin.

  logic        clk_i;
  logic        arst_n_i;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic        instr_ready_o;
  logic        result_valid_o;
  logic        result_ready_i;
  logic [4:0]  result_rd_o;
  logic [31:0] result_data_o;
  logic        result_illegal_o;

  logic [31:0] rng_state;
  logic [31:0] model_rf [32];   // reference register file.
  logic [31:0] program_q [$];
  logic [37:0] exp_q [$];       // {illegal, rd, data} per accepted word.
  logic [37:0] exp_word;
  int          directed_count;
  int          error_count;
  int          result_count;
  int          cycle_count;

  int_exec_top uut (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .instr_valid_i   (instr_valid_i),
    .instr_i         (instr_i),
    .instr_ready_o   (instr_ready_o),
    .result_valid_o  (result_valid_o),
    .result_ready_i  (result_ready_i),
    .result_rd_o     (result_rd_o),
    .result_data_o   (result_data_o),
    .result_illegal_o(result_illegal_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic rand_ready();
    return (xorshift32() % 32'd10) < 32'd7; // about 70% high.
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  // expected {illegal, rd, data}; updates the model in program order.
  function automatic logic [37:0] ref_execute(input logic [31:0] w);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        legal;
    a     = (w[19:15] == 5'd0) ? 32'd0 : model_rf[w[19:15]];
    b     = 32'd0;
    res   = 32'd0;
    legal = 1'b1;
    if (w[6:0] == 7'b0110011) begin
      b = (w[24:20] == 5'd0) ? 32'd0 : model_rf[w[24:20]];
      if (w[31:25] == 7'h20 && w[14:12] == 3'b000) begin
        res = a - b;
      end else if (w[31:25] != 7'h00) begin
        legal = 1'b0;
      end
    end else if (w[6:0] == 7'b0010011) begin
      b = {{20{w[31]}}, w[31:20]}; // sign-extended immediate.
    end else begin
      legal = 1'b0;
    end
    if (legal && !(w[6:0] == 7'b0110011 && w[31:25] == 7'h20)) begin
      case (w[14:12])
        3'b000:  res = a + b;
        3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  res = a ^ b;
        3'b110:  res = a | b;
        3'b111:  res = a & b;
        default: legal = 1'b0; // shifts and sltu.
      endcase
    end
    if (!legal) begin
      res = 32'd0;
    end else if (w[11:7] != 5'd0) begin
      model_rf[w[11:7]] = res;
    end
    return {!legal, w[11:7], res};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic build_program();
    logic [31:0] r;
    logic [31:0] r2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    for (int i = 1; i < 32; i++) begin
      r = xorshift32();
      program_q.push_back(enc_i(r[11:0], 5'd0, 3'b000, 5'(i))); // addi xi, x0, imm.
    end
    for (int i = 1; i < 32; i++) begin
      program_q.push_back(enc_r(7'h00, 5'd0, 5'(i), 3'b000, 5'(i))); // add xi, xi, x0.
    end
    program_q.push_back(enc_i(12'h155, 5'd3, 3'b000, 5'd0));   // addi x0 is dropped.
    program_q.push_back(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd9));
    program_q.push_back(enc_r(7'h00, 5'd0, 5'd0, 3'b110, 5'd10));
    program_q.push_back(enc_i(12'hfff, 5'd0, 3'b111, 5'd11));
    program_q.push_back(enc_i(12'd77, 5'd0, 3'b000, 5'd5));    // dependent chain.
    program_q.push_back(enc_r(7'h00, 5'd5, 5'd5, 3'b000, 5'd6));
    program_q.push_back(enc_r(7'h20, 5'd5, 5'd6, 3'b000, 5'd7));
    program_q.push_back(enc_i(12'hfff, 5'd7, 3'b010, 5'd8));
    program_q.push_back(enc_r(7'h00, 5'd6, 5'd7, 3'b010, 5'd12));
    program_q.push_back({12'h000, 5'd2, 3'b010, 5'd1, 7'b0000011}); // load.
    program_q.push_back(enc_r(7'h00, 5'd2, 5'd3, 3'b001, 5'd13));     // sll.
    program_q.push_back(enc_r(7'h00, 5'd2, 5'd3, 3'b011, 5'd14));     // sltu.
    program_q.push_back(enc_r(7'h20, 5'd2, 5'd3, 3'b111, 5'd15));
    program_q.push_back(enc_i(12'h405, 5'd3, 3'b101, 5'd16));         // srai.
    program_q.push_back({20'h12345, 5'd17, 7'b0110111});               // lui.
    program_q.push_back(enc_r(7'h00, 5'd0, 5'd1, 3'b000, 5'd1));
    for (int i = 13; i < 18; i++) begin
      program_q.push_back(enc_r(7'h00, 5'd0, 5'(i), 3'b000, 5'(i)));
    end
    directed_count = program_q.size();
    while (program_q.size() < num_instr_c) begin
      r  = xorshift32();
      r2 = xorshift32();
      case (r[10:8])
        3'd1:    f3 = 3'b010;
        3'd2:    f3 = 3'b100;
        3'd3:    f3 = 3'b110;
        3'd4:    f3 = 3'b111;
        default: f3 = 3'b000;
      endcase
      f7 = (f3 == 3'b000 && r[11]) ? 7'h20 : 7'h00;
      if (r[3:0] < 4'd2) begin
        program_q.push_back(r2); // raw word, mostly illegal.
      end else if (r[3:0] < 4'd9) begin
        program_q.push_back(enc_r(f7, r[16:12], r[21:17], f3, r[26:22]));
      end else begin
        program_q.push_back(enc_i(r2[11:0], r[21:17], f3, r[26:22]));
      end
    end
  endtask

  // compare on every result handshake, sampled mid-cycle.
  always @(negedge clk_i) begin
    if (arst_n_i && result_valid_o && result_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("a result arrived with no instruction outstanding");
        error_count++;
      end else begin
        exp_word = exp_q.pop_front();
        check_value($sformatf("result %0d rd", result_count), {27'b0, exp_word[36:32]},
                    {27'b0, result_rd_o});
        check_value($sformatf("result %0d data", result_count), exp_word[31:0], result_data_o);
        check_value($sformatf("result %0d illegal", result_count), {31'b0, exp_word[37]},
                    {31'b0, result_illegal_o});
      end
      result_count++;
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= max_cycles_c) begin
      $display("timeout after %0d cycles: results stopped arriving, %0d of %0d seen",
               cycle_count, result_count, num_instr_c);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    int idx;
    arst_n_i       = 1'b0;
    instr_valid_i  = 1'b0;
    instr_i        = 32'd0;
    result_ready_i = 1'b0;
    rng_state      = 32'hc327_76d3;
    error_count    = 0;
    result_count   = 0;
    cycle_count    = 0;
    idx            = 0;
    foreach (model_rf[i]) begin
      model_rf[i] = 32'd0;
    end
    build_program();
    repeat (3) @(posedge clk_i);
    #1 arst_n_i = 1'b1;
    check_value("instr_ready_o after reset", 32'd1, {31'b0, instr_ready_o});
    check_value("result_valid_o after reset", 32'd0, {31'b0, result_valid_o});
    while (idx < program_q.size()) begin
      @(posedge clk_i);
      #1;
      result_ready_i = (idx < directed_count) ? 1'b1 : rand_ready(); // no stalls while directed.
      instr_valid_i  = 1'b1;
      instr_i        = program_q[idx];
      @(negedge clk_i);
      if (instr_ready_o) begin
        exp_q.push_back(ref_execute(program_q[idx]));
        idx++;
      end
    end
    @(posedge clk_i);
    #1;
    instr_valid_i  = 1'b0;
    result_ready_i = rand_ready();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      #1;
      result_ready_i = rand_ready();
    end
    check_value("result_valid_o when drained", 32'd0, {31'b0, result_valid_o});
    check_value("result count", 32'(num_instr_c), 32'(result_count));
    $display("results checked: %0d, errors: %0d", result_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : int_exec_tb

/* int_exec_top.f */
design/rf_pkg.sv
design/alu_pkg.sv
design/rf_read_if.sv
design/dec_alu_if.sv
design/int_regfile.sv
design/instr_decoder.sv
design/alu_stage.sv
design/int_exec_top.sv
tb/int_exec_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it, and decides the result from sim.log
verilator --binary --timing --assert -f int_exec_top.f --top-module int_exec_tb \
    --Mdir obj_dir -o int_exec_sim > build.log 2>&1 \
  && ./obj_dir/int_exec_sim > sim.log 2>&1 \
  && grep -q "Verification passed" sim.log \
  && echo "run.sh: simulation OK" \
  || { echo "run.sh: build or simulation failed, see build.log and sim.log"; exit 1; }
